// ==== run.sh ====
#!/usr/bin/env bash
# build the rename testbench with Verilator, run it, judge by its output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f tb.f --top-module rename_tb -o rename_sim \
	|| exit 1
sim_out=$(./obj_dir/rename_sim)
printf '%s\n' "$sim_out"
grep -qx "All checks passed" <<< "$sim_out" && echo "run passed" \
	|| { echo "run failed"; exit 1; }

// ==== source/free_list_fifo.sv ====
////////////////////////////////////////////////////////////////////////////
// free list FIFO of physical register numbers
// preloaded at reset, one pop and up to COMMIT_WIDTH pushes per cycle
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "rename_cfg.svh"

module free_list_fifo import rename_pkg::*; (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     pop,
	input  logic [`COMMIT_WIDTH-1:0] push_en,
	input  phys_reg_t                push_phys [`COMMIT_WIDTH],
	output phys_reg_t                head_phys,
	output logic                     empty,
	output logic                     empty_next
);

	localparam int ARCH_NUM = 1 << `ARCH_REG_BITS;
	localparam int PHYS_NUM = 1 << `PHYS_REG_BITS;
	localparam int DEPTH    = PHYS_NUM + 1;        // one spare slot, ptrs never collide
	localparam int PTR_W    = `PHYS_REG_BITS + 1;
	localparam int PRELOAD  = PHYS_NUM - ARCH_NUM; // regs not mapped at reset

	typedef logic [PTR_W-1:0] ptr_t;

	phys_reg_t mem [DEPTH];
	ptr_t      rd_ptr;
	ptr_t      wr_ptr;
	ptr_t      count;       // entries held now
	ptr_t      count_next;  // entries after this cycle
	ptr_t      push_cnt;    // enabled push slots this cycle
	ptr_t      wr_idx [`COMMIT_WIDTH];
	logic      do_pop;

	// pointer add modulo DEPTH
	function automatic ptr_t wrap_add(input ptr_t base, input ptr_t inc);
		int sum;
		sum = int'(base) + int'(inc);
		if (sum >= DEPTH)
			sum -= DEPTH;
		return ptr_t'(sum);
	endfunction

	// each enabled slot lands after the enabled slots below it
	always_comb begin
		ptr_t ofs;
		ofs = '0;
		for (int i = 0; i < `COMMIT_WIDTH; i++) begin
			wr_idx[i] = wrap_add(wr_ptr, ofs);
			if (push_en[i])
				ofs = ofs + 1'b1; // compact, no holes
		end
		push_cnt = ofs;
	end

	assign empty      = (count == '0);
	assign do_pop     = pop & ~empty;     // pop on empty is dropped
	assign count_next = count - ptr_t'(do_pop) + push_cnt;
	assign empty_next = (count_next == '0);
	assign head_phys  = mem[rd_ptr];      // next free reg, valid when !empty

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			// free regs ARCH_NUM .. PHYS_NUM-1 ascending
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= (i < PRELOAD) ? phys_reg_t'(i + ARCH_NUM) : '0;
			end
			rd_ptr <= '0;
			wr_ptr <= ptr_t'(PRELOAD);
			count  <= ptr_t'(PRELOAD);
		end else begin
			for (int i = 0; i < `COMMIT_WIDTH; i++) begin
				if (push_en[i])
					mem[wr_idx[i]] <= push_phys[i];
			end
			if (do_pop)
				rd_ptr <= wrap_add(rd_ptr, ptr_t'(1));
			wr_ptr <= wrap_add(wr_ptr, push_cnt);
			count  <= count_next;
		end
	end

endmodule

// ==== source/rename_cfg.svh ====
////////////////////////////////////////////////////////////////////////////
// rename subsystem configuration
// register space sizes, commit width and retire queue depth
////////////////////////////////////////////////////////////////////////////
`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

// architectural register number width, 3 -> 8 registers
`define ARCH_REG_BITS 3

// physical register number width, 5 -> 32 registers
`define PHYS_REG_BITS 5

// max commits per cycle
`define COMMIT_WIDTH 2

// retire queue index width, 4 -> 16 entries
`define RETIRE_DEPTH_BITS 4

`endif

// ==== source/rename_map.sv ====
////////////////////////////////////////////////////////////////////////////
// rename stage
// map table, displaced register table, allocation and release
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "rename_cfg.svh"

module rename_map import rename_pkg::*; (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     inst_valid,
	input  logic                     dst_write,
	input  arch_reg_t                src1,
	input  arch_reg_t                src2,
	input  arch_reg_t                dst,
	input  logic [`COMMIT_WIDTH-1:0] commit_valid,
	input  logic [`COMMIT_WIDTH-1:0] commit_write,
	input  phys_reg_t                commit_phys [`COMMIT_WIDTH],
	input  logic                     queue_full,
	output logic                     rename_ready,
	output logic                     out_valid,
	output phys_reg_t                phys_src1,
	output phys_reg_t                phys_src2,
	output phys_reg_t                phys_dst,
	output logic                     alloc_write,
	output phys_reg_t                alloc_phys
);

	localparam int ARCH_NUM = 1 << `ARCH_REG_BITS;
	localparam int PHYS_NUM = 1 << `PHYS_REG_BITS;

	phys_reg_t             map_tbl [ARCH_NUM];   // speculative arch -> phys
	phys_reg_t             disp_phys [PHYS_NUM]; // reg displaced by each phys reg
	logic [PHYS_NUM-1:0]   disp_valid;           // displaced entry recorded

	phys_reg_t                fl_head;
	logic                     fl_empty;
	logic                     fl_empty_next;
	logic                     fl_pop;
	logic [`COMMIT_WIDTH-1:0] rel_en;            // release per commit slot
	phys_reg_t                rel_phys [`COMMIT_WIDTH];
	phys_reg_t                dst_next;          // phys_dst for this instruction

	free_list_fifo free_list_i (
		.clk        (clk),
		.reset      (reset),
		.pop        (fl_pop),
		.push_en    (rel_en),
		.push_phys  (rel_phys),
		.head_phys  (fl_head),
		.empty      (fl_empty),
		.empty_next (fl_empty_next)
	);

	// a write takes the free list head
	assign fl_pop      = inst_valid & dst_write & ~fl_empty;
	assign dst_next    = fl_pop ? fl_head : map_tbl[dst]; // no write keeps old mapping
	assign alloc_write = fl_pop;
	assign alloc_phys  = dst_next; // into retire queue entry

	// committed write frees the reg it displaced
	always_comb begin
		for (int i = 0; i < `COMMIT_WIDTH; i++) begin
			rel_en[i]   = commit_valid[i] & commit_write[i] & disp_valid[commit_phys[i]];
			rel_phys[i] = disp_phys[commit_phys[i]];
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < ARCH_NUM; i++) begin
				map_tbl[i] <= phys_reg_t'(i); // identity map
			end
			disp_valid <= '0;
		end else begin
			for (int i = 0; i < `COMMIT_WIDTH; i++) begin
				if (rel_en[i])
					disp_valid[commit_phys[i]] <= 1'b0;
			end
			// head reg is free, so never also a release target
			if (fl_pop) begin
				map_tbl[dst]        <= fl_head;
				disp_valid[fl_head] <= 1'b1;
			end
		end
	end

	// displaced reg recorded against the new one
	always_ff @(posedge clk) begin
		if (fl_pop)
			disp_phys[fl_head] <= map_tbl[dst];
	end

	// stage output register
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			out_valid    <= 1'b0;
			rename_ready <= 1'b1;
		end else begin
			out_valid    <= inst_valid;
			rename_ready <= ~fl_empty_next & ~queue_full; // state of next cycle
		end
	end

	// sources read before this instruction's own write
	always_ff @(posedge clk) begin
		if (inst_valid) begin
			phys_src1 <= map_tbl[src1];
			phys_src2 <= map_tbl[src2];
			phys_dst  <= dst_next;
		end
	end

endmodule

// ==== source/rename_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// rename subsystem types
// register numbers, commit counts and retire queue indices
////////////////////////////////////////////////////////////////////////////
`include "rename_cfg.svh"

package rename_pkg;

	// architectural register number
	typedef logic [`ARCH_REG_BITS-1:0] arch_reg_t;

	// physical register number
	typedef logic [`PHYS_REG_BITS-1:0] phys_reg_t;

	// commit count, 0 up to COMMIT_WIDTH
	typedef logic [1:0] commit_cnt_t;

	// retire queue pointer, wraps naturally at queue depth
	typedef logic [`RETIRE_DEPTH_BITS-1:0] rq_index_t;

endpackage

// ==== source/rename_top.sv ====
////////////////////////////////////////////////////////////////////////////
// register rename subsystem top
// rename stage with free list, plus in-order retire queue
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "rename_cfg.svh"

module rename_top import rename_pkg::*; (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     inst_valid,  // one-cycle strobe
	input  arch_reg_t                src1,
	input  arch_reg_t                src2,
	input  arch_reg_t                dst,
	input  logic                     dst_write,
	input  logic                     retire_req,  // one-cycle strobe
	input  commit_cnt_t              retire_count,
	output logic                     rename_ready,
	output logic                     out_valid,
	output phys_reg_t                phys_src1,
	output phys_reg_t                phys_src2,
	output phys_reg_t                phys_dst,
	output logic [`COMMIT_WIDTH-1:0] commit_valid,
	output logic [`COMMIT_WIDTH-1:0] commit_write,
	output phys_reg_t                commit_phys [`COMMIT_WIDTH]
);

	logic      queue_full;
	logic      alloc_write; // new entry is a write
	phys_reg_t alloc_phys;

	rename_map rename_i (
		.clk          (clk),
		.reset        (reset),
		.inst_valid   (inst_valid),
		.dst_write    (dst_write),
		.src1         (src1),
		.src2         (src2),
		.dst          (dst),
		.commit_valid (commit_valid),
		.commit_write (commit_write),
		.commit_phys  (commit_phys),
		.queue_full   (queue_full),
		.rename_ready (rename_ready),
		.out_valid    (out_valid),
		.phys_src1    (phys_src1),
		.phys_src2    (phys_src2),
		.phys_dst     (phys_dst),
		.alloc_write  (alloc_write),
		.alloc_phys   (alloc_phys)
	);

	// every strobed instruction takes a queue entry
	retire_queue retire_i (
		.clk          (clk),
		.reset        (reset),
		.accept       (inst_valid),
		.entry_write  (alloc_write),
		.entry_phys   (alloc_phys),
		.retire_req   (retire_req),
		.retire_count (retire_count),
		.commit_valid (commit_valid),
		.commit_write (commit_write),
		.commit_phys  (commit_phys),
		.full         (queue_full)
	);

endmodule

// ==== source/retire_queue.sv ====
////////////////////////////////////////////////////////////////////////////
// in-order retire queue
// holds renamed writes, drains up to COMMIT_WIDTH per retire request
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "rename_cfg.svh"

module retire_queue import rename_pkg::*; (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     accept,
	input  logic                     entry_write,
	input  phys_reg_t                entry_phys,
	input  logic                     retire_req,
	input  commit_cnt_t              retire_count,
	output logic [`COMMIT_WIDTH-1:0] commit_valid,
	output logic [`COMMIT_WIDTH-1:0] commit_write,
	output phys_reg_t                commit_phys [`COMMIT_WIDTH],
	output logic                     full
);

	localparam int DEPTH = 1 << `RETIRE_DEPTH_BITS;

	typedef logic [`RETIRE_DEPTH_BITS:0] occ_t; // 0 .. DEPTH

	logic [DEPTH-1:0] q_write;        // entry is a register write
	phys_reg_t        q_phys [DEPTH]; // allocated or current dst mapping
	rq_index_t        rd_ptr;         // oldest entry
	rq_index_t        wr_ptr;
	occ_t             count;
	occ_t             count_next;
	commit_cnt_t      n_ret;          // entries leaving this cycle
	logic             do_push;

	// min(retire_count, COMMIT_WIDTH, occupancy)
	always_comb begin
		commit_cnt_t lim;
		lim = (retire_count > commit_cnt_t'(`COMMIT_WIDTH)) ?
			commit_cnt_t'(`COMMIT_WIDTH) : retire_count;
		if (!retire_req)
			n_ret = '0;
		else if (count < occ_t'(lim))
			n_ret = commit_cnt_t'(count); // fewer than asked
		else
			n_ret = lim;
	end

	assign do_push    = accept & (count != occ_t'(DEPTH)); // drop when already full
	assign count_next = count + occ_t'(do_push) - occ_t'(n_ret);
	assign full       = (count_next == occ_t'(DEPTH));     // full as of next cycle

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rd_ptr       <= '0;
			wr_ptr       <= '0;
			count        <= '0;
			commit_valid <= '0;
			commit_write <= '0;
		end else begin
			// slot 0 gets the oldest
			for (int i = 0; i < `COMMIT_WIDTH; i++) begin
				commit_valid[i] <= (commit_cnt_t'(i) < n_ret);
				commit_write[i] <= (commit_cnt_t'(i) < n_ret) &
					q_write[rd_ptr + rq_index_t'(i)];
			end
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			rd_ptr <= rd_ptr + rq_index_t'(n_ret);
			count  <= count_next;
		end
	end

	// entry storage and commit payload
	always_ff @(posedge clk) begin
		if (do_push) begin
			q_write[wr_ptr] <= entry_write;
			q_phys[wr_ptr]  <= entry_phys;
		end
		for (int i = 0; i < `COMMIT_WIDTH; i++) begin
			commit_phys[i] <= q_phys[rd_ptr + rq_index_t'(i)]; // qualified by commit_valid
		end
	end

endmodule

// ==== tb.f ====
+incdir+source
source/rename_pkg.sv
source/free_list_fifo.sv
source/rename_map.sv
source/retire_queue.sv
source/rename_top.sv
test/rename_clock.sv
test/rename_tb.sv

// ==== test/rename_clock.sv ====
////////////////////////////////////////////////////////////////////////////
// rename testbench clock and reset
// 4 ns clock, reset held high for five cycles
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rename_clock (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	// release on a falling edge, away from the DUT's clock edge
	initial begin
		reset = 1'b1;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

// ==== test/rename_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// rename subsystem testbench
// directed and random renames and retires checked against a reference model
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "rename_cfg.svh"

module rename_tb import rename_pkg::*; ();

	localparam int ARCH_NUM    = 1 << `ARCH_REG_BITS;
	localparam int PHYS_NUM    = 1 << `PHYS_REG_BITS;
	localparam int RQ_DEPTH    = 1 << `RETIRE_DEPTH_BITS;
	localparam int CW          = `COMMIT_WIDTH;
	localparam int CYCLE_LIMIT = 4000; // five tests of up to 600 cycles plus margin

	logic          clk;
	logic          reset;
	logic          inst_valid;
	arch_reg_t     src1;
	arch_reg_t     src2;
	arch_reg_t     dst;
	logic          dst_write;
	logic          retire_req;
	commit_cnt_t   retire_count;
	logic          rename_ready;
	logic          out_valid;
	phys_reg_t     phys_src1;
	phys_reg_t     phys_src2;
	phys_reg_t     phys_dst;
	logic [CW-1:0] commit_valid;
	logic [CW-1:0] commit_write;
	phys_reg_t     commit_phys [CW];

	// reference state
	phys_reg_t m_map [ARCH_NUM];
	phys_reg_t m_disp [PHYS_NUM]; // displaced reg per newly allocated reg
	phys_reg_t m_free [$];        // free regs in release order
	logic      m_rq_write [$];    // retire queue in age order
	phys_reg_t m_rq_phys [$];

	// expected outputs for this cycle (cur) and the next one (nxt)
	logic          cur_ready;
	logic          nxt_ready;
	logic          cur_ov;
	logic          nxt_ov;
	phys_reg_t     cur_ps1;
	phys_reg_t     nxt_ps1;
	phys_reg_t     cur_ps2;
	phys_reg_t     nxt_ps2;
	phys_reg_t     cur_pd;
	phys_reg_t     nxt_pd;
	logic [CW-1:0] cur_cvalid;
	logic [CW-1:0] nxt_cvalid;
	logic [CW-1:0] cur_cwrite;
	logic [CW-1:0] nxt_cwrite;
	phys_reg_t     cur_cphys [CW];
	phys_reg_t     nxt_cphys [CW];

	logic checking;       // compare enabled once stimulus runs
	int   errors;
	int   test_err_base;
	int   test_count;
	int   cycles_checked;
	int   cycles;

	rename_clock clock_i (
		.clk   (clk),
		.reset (reset)
	);

	rename_top dut_i (
		.clk          (clk),
		.reset        (reset),
		.inst_valid   (inst_valid),
		.src1         (src1),
		.src2         (src2),
		.dst          (dst),
		.dst_write    (dst_write),
		.retire_req   (retire_req),
		.retire_count (retire_count),
		.rename_ready (rename_ready),
		.out_valid    (out_valid),
		.phys_src1    (phys_src1),
		.phys_src2    (phys_src2),
		.phys_dst     (phys_dst),
		.commit_valid (commit_valid),
		.commit_write (commit_write),
		.commit_phys  (commit_phys)
	);

	// reset state of map, free list and queue
	function automatic void init_reference();
		for (int i = 0; i < ARCH_NUM; i++)
			m_map[i] = phys_reg_t'(i);
		m_free.delete();
		for (int i = ARCH_NUM; i < PHYS_NUM; i++)
			m_free.push_back(phys_reg_t'(i));
		m_rq_write.delete();
		m_rq_phys.delete();
		nxt_ready  = 1'b1;
		nxt_ov     = 1'b0;
		nxt_cvalid = '0;
		nxt_cwrite = '0;
		cur_ready  = 1'b1;
		cur_ov     = 1'b0;
		cur_cvalid = '0;
		cur_cwrite = '0;
	endfunction

	// one rename with sources read before its own write
	function automatic void model_rename(input arch_reg_t s1, input arch_reg_t s2,
		input arch_reg_t d, input logic w);
		logic alloc;
		alloc   = w && (m_free.size() > 0);
		nxt_ps1 = m_map[s1];
		nxt_ps2 = m_map[s2];
		if (alloc) begin
			nxt_pd         = m_free.pop_front(); // oldest free reg
			m_disp[nxt_pd] = m_map[d];
			m_map[d]       = nxt_pd;
		end else begin
			nxt_pd = m_map[d]; // mapping unchanged
		end
		m_rq_write.push_back(alloc);
		m_rq_phys.push_back(nxt_pd);
	endfunction

	// frees regs of this cycle's commits and picks next cycle's commit slots
	function automatic void commit_oldest(input logic rr, input commit_cnt_t rc,
		input int rq_start);
		int n;
		for (int i = 0; i < CW; i++) begin
			if (cur_cvalid[i] && cur_cwrite[i])
				m_free.push_back(m_disp[cur_cphys[i]]); // slot order
		end
		n = rr ? int'(rc) : 0;
		if (n > CW)
			n = CW;
		if (n > rq_start)
			n = rq_start; // only entries held at cycle start
		for (int i = 0; i < CW; i++) begin
			nxt_cvalid[i] = (i < n);
			nxt_cwrite[i] = 1'b0;
			if (i < n) begin
				nxt_cwrite[i] = m_rq_write.pop_front();
				nxt_cphys[i]  = m_rq_phys.pop_front();
			end
		end
	endfunction

	function automatic void report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		errors++;
		$display("FAIL %s got %0h expected %0h at %0t", name, got, exp, $time);
	endfunction

	// one falling edge of stimulus with the model stepped alongside
	task automatic drive_cycle(input logic want, input arch_reg_t s1, input arch_reg_t s2,
		input arch_reg_t d, input logic w, input logic rr, input commit_cnt_t rc,
		output logic took);
		int rq_start;
		@(negedge clk);
		cur_ready  = nxt_ready;
		cur_ov     = nxt_ov;
		cur_ps1    = nxt_ps1;
		cur_ps2    = nxt_ps2;
		cur_pd     = nxt_pd;
		cur_cvalid = nxt_cvalid;
		cur_cwrite = nxt_cwrite;
		cur_cphys  = nxt_cphys;
		checking   = 1'b1;
		took         = want & rename_ready; // strobe only while ready
		inst_valid   = took;
		src1         = s1;
		src2         = s2;
		dst          = d;
		dst_write    = w;
		retire_req   = rr;
		retire_count = rc;
		rq_start = m_rq_phys.size();
		nxt_ov   = took;
		if (took)
			model_rename(s1, s2, d, w);
		commit_oldest(rr, rc, rq_start);
		nxt_ready = (m_free.size() > 0) && (m_rq_phys.size() < RQ_DEPTH);
	endtask

	// retries until accepted and repeats the retire request on each try
	task automatic issue_inst(input arch_reg_t s1, input arch_reg_t s2, input arch_reg_t d,
		input logic w, input logic rr, input commit_cnt_t rc);
		logic took;
		took = 1'b0;
		while (!took)
			drive_cycle(1'b1, s1, s2, d, w, rr, rc, took);
	endtask

	task automatic idle_cycles(input int n);
		logic took;
		for (int i = 0; i < n; i++)
			drive_cycle(1'b0, '0, '0, '0, 1'b0, 1'b0, '0, took);
	endtask

	task automatic retire_once(input commit_cnt_t rc);
		logic took;
		drive_cycle(1'b0, '0, '0, '0, 1'b0, 1'b1, rc, took);
	endtask

	// drain all entries and let the last commits and releases show
	task automatic drain_queue();
		while (m_rq_phys.size() > 0)
			retire_once(2'd2);
		idle_cycles(2);
	endtask

	task automatic finish_test(input string name);
		test_count++;
		$display("test %0d %s done, %0d mismatches", test_count, name,
			errors - test_err_base);
		test_err_base = errors;
	endtask

	// DUT outputs of the cycle just ending before this edge updates them
	always @(posedge clk) begin
		if (checking) begin
			cycles_checked++;
			if (rename_ready !== cur_ready)
				report_mismatch("rename_ready", 32'(rename_ready), 32'(cur_ready));
			if (out_valid !== cur_ov)
				report_mismatch("out_valid", 32'(out_valid), 32'(cur_ov));
			else if (cur_ov) begin
				if (phys_src1 !== cur_ps1)
					report_mismatch("phys_src1", 32'(phys_src1), 32'(cur_ps1));
				if (phys_src2 !== cur_ps2)
					report_mismatch("phys_src2", 32'(phys_src2), 32'(cur_ps2));
				if (phys_dst !== cur_pd)
					report_mismatch("phys_dst", 32'(phys_dst), 32'(cur_pd));
			end
			for (int i = 0; i < CW; i++) begin
				if (commit_valid[i] !== cur_cvalid[i])
					report_mismatch($sformatf("commit_valid[%0d]", i),
						32'(commit_valid[i]), 32'(cur_cvalid[i]));
				else if (cur_cvalid[i]) begin
					if (commit_write[i] !== cur_cwrite[i])
						report_mismatch($sformatf("commit_write[%0d]", i),
							32'(commit_write[i]), 32'(cur_cwrite[i]));
					if (commit_phys[i] !== cur_cphys[i])
						report_mismatch($sformatf("commit_phys[%0d]", i),
							32'(commit_phys[i]), 32'(cur_cphys[i]));
				end
			end
		end
	end

	// watchdog
	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("run stopped, still going after %0d cycles", CYCLE_LIMIT);
		$display("Checks failed");
		$finish;
	end

	initial begin
		logic took;
		logic saw_low;
		logic want;
		logic wr;
		logic rr;
		void'($urandom(32'hf6acf458));
		inst_valid   = 1'b0;
		src1         = '0;
		src2         = '0;
		dst          = '0;
		dst_write    = 1'b0;
		retire_req   = 1'b0;
		retire_count = '0;
		checking       = 1'b0;
		errors         = 0;
		test_err_base  = 0;
		test_count     = 0;
		cycles_checked = 0;
		init_reference();
		@(negedge reset);

		// reads only so every source sees its identity mapping
		for (int i = 0; i < ARCH_NUM; i++)
			issue_inst(arch_reg_t'(i), arch_reg_t'(ARCH_NUM - 1 - i), arch_reg_t'(i),
				1'b0, 1'b0, '0);
		drain_queue();
		finish_test("reset mappings");

		// back to back writes take 8, 9, 10 ... then reads see them
		for (int i = 0; i < ARCH_NUM; i++)
			issue_inst(arch_reg_t'(i - 1), arch_reg_t'(i), arch_reg_t'(i), 1'b1, 1'b0, '0);
		for (int i = 0; i < 6; i++)
			issue_inst(arch_reg_t'(i), arch_reg_t'(i + 3), arch_reg_t'(i), 1'b0, 1'b0, '0);
		drain_queue();
		finish_test("back to back writes");

		// no-write instructions between two writes consume no reg
		issue_inst(arch_reg_t'(5), arch_reg_t'(1), arch_reg_t'(5), 1'b1, 1'b0, '0);
		for (int i = 0; i < 4; i++)
			issue_inst(arch_reg_t'(5), arch_reg_t'(i), arch_reg_t'(i + 4), 1'b0, 1'b0, '0);
		issue_inst(arch_reg_t'(5), arch_reg_t'(2), arch_reg_t'(5), 1'b1, 1'b0, '0);
		issue_inst(arch_reg_t'(5), arch_reg_t'(5), arch_reg_t'(5), 1'b0, 1'b0, '0);
		drain_queue();
		finish_test("writes and non-writes");

		// retire counts 0, 1, 2, and 2 with only one entry left
		for (int i = 0; i < 6; i++)
			issue_inst(arch_reg_t'(3), arch_reg_t'(i), arch_reg_t'(3), 1'b1, 1'b0, '0);
		retire_once(2'd0);
		retire_once(2'd1);
		retire_once(2'd2);
		retire_once(2'd2);
		retire_once(2'd2);
		idle_cycles(2);
		// enough writes to wrap the free list onto released regs
		for (int k = 0; k < 40; k++)
			issue_inst(arch_reg_t'(k), arch_reg_t'(k + 3), arch_reg_t'(k), 1'b1,
				k[0], 2'd2);
		drain_queue();
		finish_test("retire counts and reuse");

		// queue fills first since at least 6 regs stay free with 16 entries in flight
		saw_low = 1'b0;
		for (int k = 0; k < 2 * RQ_DEPTH && !saw_low; k++) begin
			drive_cycle(1'b1, arch_reg_t'(k), arch_reg_t'(k + 1), arch_reg_t'(k), 1'b1,
				1'b0, '0, took);
			if (!took)
				saw_low = 1'b1;
		end
		if (!saw_low) begin
			errors++;
			$display("rename_ready stayed high through %0d writes with no retirement",
				2 * RQ_DEPTH);
		end
		drain_queue();
		// random mix of renames and retires
		for (int k = 0; k < 500; k++) begin
			want = ($urandom % 2) == 0;
			wr   = ($urandom % 4) != 0; // mostly writes
			rr   = ($urandom % 2) == 0;
			drive_cycle(want, arch_reg_t'($urandom), arch_reg_t'($urandom),
				arch_reg_t'($urandom), wr, rr, commit_cnt_t'($urandom % 3), took);
		end
		drain_queue();
		finish_test("full queue and random mix");

		@(negedge clk); // last compare
		$display("%0d tests, %0d cycles compared, %0d mismatches", test_count,
			cycles_checked, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule
